//--- logic/hyperram_pkg.sv
package hyperram_pkg;

	//////////////////////////////////////////////////////////////////////
	// Command/address layout

	// Three CA words carry 48 bits, first word on top
	// 47 rd, 46 register space, 45 linear, 44:16 upper address,
	// 15:3 reserved zeros, 2:0 lower column
	localparam int CA_UPPER_W = 29;	// Row plus upper column bits
	localparam int CA_LOWER_W = 3;	// Word within a 16-byte page
	localparam int CA_RSVD_W  = 13;	// Always zero
	localparam int LEN_W      = 8;	// Burst length counter width

	// One burst on the PHY channel
	typedef struct packed {
		logic                  rd;			// 1 = read
		logic                  is_reg;		// Register space, not memory
		logic                  is_linear;	// 0 = wrapped
		logic [CA_UPPER_W-1:0] upper_addr;
		logic [CA_LOWER_W-1:0] lower_addr;
		logic [LEN_W-1:0]      len;			// In 16-bit words
	} burst_req_t;

	//////////////////////////////////////////////////////////////////////
	// Pad-side word registers

	typedef struct packed {
		logic        cs_n;
		logic        rst_n;
		logic        ck_en;		// RAM clock running
		logic [15:0] dq;		// One DDR beat pair per clk
		logic        dq_oe;
		logic [1:0]  dm;		// Write mask on RWDS
		logic        dqs_oe;
	} hr_pins_out_t;

	typedef struct packed {
		logic [15:0] dq;
		logic [1:0]  dqs;		// RWDS sampled on both edges
	} hr_pins_in_t;

	//////////////////////////////////////////////////////////////////////
	// State encodings

	typedef enum logic [3:0] {
		PHY_IDLE       = 4'h0,
		PHY_UADDR      = 4'h1,
		PHY_LADDR      = 4'h2,
		PHY_DQS_WAIT   = 4'h3,
		PHY_PRE_DATA   = 4'h4,
		PHY_READ_DATA  = 4'h5,
		PHY_WRITE_WAIT = 4'h6,
		PHY_WRITE_DATA = 4'h7,
		PHY_WRITE_LAST = 4'h8
	} phy_state_t;

	typedef enum logic [2:0] {
		BOOT_RST_LOW   = 3'h0,
		BOOT_RST_WAIT  = 3'h1,
		BOOT_ID_READ   = 3'h2,
		BOOT_CR0_WRITE = 3'h3,
		BOOT_DONE      = 3'h4
	} boot_state_t;

	//////////////////////////////////////////////////////////////////////
	// Device constants

	localparam logic [15:0] CR0_VALUE = {
		1'b1,		// Normal operation
		3'b011,		// 46 ohm drive
		4'b1111,	// Reserved ones
		4'b0001,	// 6 clock latency
		1'b1,		// Fixed latency
		1'b1,		// Legacy wrapped order
		2'b11		// 32 byte burst
	};
	localparam logic [CA_UPPER_W-1:0] CR0_UPPER_ADDR = 29'h100;
	localparam logic [3:0]            ID_VENDOR      = 4'h1;
	localparam logic [4:0]            CAP_SHIFT_BIAS = 5'd14;	// Offset-1 coded fields

endpackage

//--- logic/hyperram_phy.sv
`timescale 1ns/1ns
module hyperram_phy #(
	parameter int WRITE_LATENCY = 9
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ram_rst_n,
	input  logic                       req,
	input  hyperram_pkg::burst_req_t   burst,
	input  logic [15:0]                wdata,
	input  hyperram_pkg::hr_pins_in_t  ram_in,
	output hyperram_pkg::hr_pins_out_t ram_out,
	output logic                       need_wdata,
	output logic                       rdata_valid,
	output logic [15:0]                rdata,
	output logic                       done
);

	localparam int LW = $clog2(WRITE_LATENCY + 1);
	localparam logic [LW-1:0] LAT_INIT = LW'(WRITE_LATENCY);
	localparam logic [LW-1:0] LAT_ONE  = LW'(1);
	localparam logic [hyperram_pkg::LEN_W-1:0] CNT_ONE   = 1;
	localparam logic [hyperram_pkg::LEN_W-1:0] CNT_THREE = 3;

	hyperram_pkg::phy_state_t state;
	hyperram_pkg::burst_req_t cur;			// Request held for the whole burst

	logic        cs_n;
	logic        ck_en;
	logic        dq_oe;
	logic        dqs_oe;
	logic [15:0] dq;
	logic [hyperram_pkg::LEN_W-1:0] word_cnt;	// Words left in the burst
	logic [LW-1:0] lat_cnt;

	logic [15:0] dq_prev;
	logic [1:0]  dqs_prev;
	logic [15:0] in_word;
	logic        in_valid;
	logic        rd_capture;

	assign ram_out = '{
		cs_n:   cs_n,
		rst_n:  ram_rst_n,		// Straight from the boot sequencer
		ck_en:  ck_en,
		dq:     dq,
		dq_oe:  dq_oe,
		dm:     2'b00,			// Full words only, never masked
		dqs_oe: dqs_oe
	};

	//////////////////////////////////////////////////////////////////////
	// Inbound alignment

	always_ff @(posedge clk) begin
		dq_prev  <= ram_in.dq;
		dqs_prev <= ram_in.dqs;
	end

	always_comb begin
		in_word  = 16'h0000;
		in_valid = 1'b0;
		if (ram_in.dqs == 2'b10) begin
			in_word  = ram_in.dq;							// Already on a word boundary
			in_valid = 1'b1;
		end else if (ram_in.dqs == 2'b01) begin
			in_word  = {dq_prev[7:0], ram_in.dq[15:8]};		// Slip half a word
			in_valid = (dqs_prev == 2'b01);					// First slipped beat is half empty
		end
	end

	assign rd_capture = (state == hyperram_pkg::PHY_PRE_DATA) ||
		(state == hyperram_pkg::PHY_READ_DATA);

	//////////////////////////////////////////////////////////////////////
	// Burst FSM

	always_ff @(posedge clk) begin
		need_wdata  <= 1'b0;
		rdata_valid <= 1'b0;
		done        <= 1'b0;
		if (rst) begin
			state    <= hyperram_pkg::PHY_IDLE;
			cs_n     <= 1'b1;
			ck_en    <= 1'b0;
			dq_oe    <= 1'b0;
			dqs_oe   <= 1'b0;
			dq       <= 16'h0000;
			word_cnt <= '0;
			lat_cnt  <= '0;
		end else begin
			case (state)
				hyperram_pkg::PHY_IDLE: begin
					if (req) begin
						cur   <= burst;
						cs_n  <= 1'b0;
						ck_en <= 1'b1;
						dq_oe <= 1'b1;
						dq    <= {burst.rd, burst.is_reg, burst.is_linear, burst.upper_addr[28:16]};
						state <= hyperram_pkg::PHY_UADDR;
					end
				end
				hyperram_pkg::PHY_UADDR: begin
					dq         <= cur.upper_addr[15:0];
					need_wdata <= !cur.rd && cur.is_reg;	// Register word goes out right after CA
					state      <= hyperram_pkg::PHY_LADDR;
				end
				hyperram_pkg::PHY_LADDR: begin
					dq       <= {{hyperram_pkg::CA_RSVD_W{1'b0}}, cur.lower_addr};
					word_cnt <= cur.len;
					if (cur.rd)
						state <= hyperram_pkg::PHY_DQS_WAIT;
					else if (cur.is_reg)
						state <= hyperram_pkg::PHY_WRITE_DATA;	// No latency for registers
					else begin
						dqs_oe  <= 1'b1;						// Drive the mask for memory writes
						lat_cnt <= LAT_INIT;
						state   <= hyperram_pkg::PHY_WRITE_WAIT;
					end
				end

				// Read path
				hyperram_pkg::PHY_DQS_WAIT: begin
					dq_oe <= 1'b0;								// Turn the bus around
					if (ram_in.dqs == 2'b00)
						state <= hyperram_pkg::PHY_PRE_DATA;	// Command taken
				end
				hyperram_pkg::PHY_PRE_DATA: begin
					if (ram_in.dqs != 2'b00)
						state <= hyperram_pkg::PHY_READ_DATA;
				end
				hyperram_pkg::PHY_READ_DATA: begin
					state <= hyperram_pkg::PHY_READ_DATA;		// Left by the capture below
				end

				// Write path
				hyperram_pkg::PHY_WRITE_WAIT: begin
					lat_cnt    <= lat_cnt - 1'b1;
					need_wdata <= (lat_cnt <= LAT_ONE);			// First two words
					if (lat_cnt == '0)
						state <= hyperram_pkg::PHY_WRITE_DATA;
				end
				hyperram_pkg::PHY_WRITE_DATA: begin
					dq         <= wdata;
					word_cnt   <= word_cnt - 1'b1;
					need_wdata <= (word_cnt >= CNT_THREE);		// Two words ahead
					if (word_cnt == CNT_ONE)
						state <= hyperram_pkg::PHY_WRITE_LAST;
				end
				hyperram_pkg::PHY_WRITE_LAST: begin
					cs_n   <= 1'b1;
					ck_en  <= 1'b0;
					dq_oe  <= 1'b0;
					dqs_oe <= 1'b0;
					dq     <= 16'h0000;							// Stop toggling
					done   <= 1'b1;
					state  <= hyperram_pkg::PHY_IDLE;
				end
				default: state <= hyperram_pkg::PHY_IDLE;
			endcase

			// Words can land as soon as the strobe starts moving
			if (rd_capture && in_valid) begin
				rdata_valid <= 1'b1;
				rdata       <= in_word;
				word_cnt    <= word_cnt - 1'b1;
				if (word_cnt == CNT_ONE) begin
					cs_n  <= 1'b1;
					ck_en <= 1'b0;
					done  <= 1'b1;
					state <= hyperram_pkg::PHY_IDLE;
				end
			end
		end
	end

	// The RAM owns DQ for the whole data phase of a read
	assert property (@(posedge clk) disable iff (rst)
		state == hyperram_pkg::PHY_READ_DATA |-> !dq_oe)
		else $error("dq_oe high in read data state");

endmodule

//--- logic/hyperram_boot.sv
`timescale 1ns/1ns
module hyperram_boot #(
	parameter int RST_LOW_CYCLES  = 64,
	parameter int RST_WAIT_CYCLES = 128
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     need_wdata,
	input  logic                     rdata_valid,
	input  logic [15:0]              rdata,
	input  logic                     done,
	output logic                     ram_rst_n,
	output logic                     req,
	output hyperram_pkg::burst_req_t req_burst,
	output logic [15:0]              wdata,
	output logic                     status_valid,
	output logic                     ram_ok,
	output logic [4:0]               num_col_addrs,
	output logic [5:0]               num_row_addrs,
	output logic [7:0]               capacity_mbits
);

	localparam int CW = $clog2(RST_LOW_CYCLES + RST_WAIT_CYCLES + 1);

	hyperram_pkg::boot_state_t state;
	logic [CW-1:0] count;
	logic [5:0]    cap_shift;		// log2 of capacity in Mbit

	// Words per die is 2^(cols+rows), 1 Mbit is 2^16 words
	assign cap_shift = {2'b00, rdata[7:4]} + {1'b0, rdata[12:8]} -
		{1'b0, hyperram_pkg::CAP_SHIFT_BIAS};

	//////////////////////////////////////////////////////////////////////
	// Boot FSM

	always_ff @(posedge clk) begin
		req <= 1'b0;
		if (rst) begin
			state          <= hyperram_pkg::BOOT_RST_LOW;
			count          <= '0;
			ram_rst_n      <= 1'b1;
			status_valid   <= 1'b0;
			ram_ok         <= 1'b0;
			num_col_addrs  <= 5'd0;
			num_row_addrs  <= 6'd0;
			capacity_mbits <= 8'd0;
		end else begin
			case (state)
				hyperram_pkg::BOOT_RST_LOW: begin
					ram_rst_n <= 1'b0;
					count     <= count + 1'b1;
					if (count == CW'(RST_LOW_CYCLES)) begin
						ram_rst_n <= 1'b1;			// Release after the full low time
						count     <= '0;
						state     <= hyperram_pkg::BOOT_RST_WAIT;
					end
				end
				hyperram_pkg::BOOT_RST_WAIT: begin
					count <= count + 1'b1;
					if (count == CW'(RST_WAIT_CYCLES - 1)) begin
						req       <= 1'b1;			// Read ID register 0, one word
						req_burst <= '{rd: 1'b1, is_reg: 1'b1, is_linear: 1'b1,
							upper_addr: '0, lower_addr: '0, len: 8'd1};
						state     <= hyperram_pkg::BOOT_ID_READ;
					end
				end
				hyperram_pkg::BOOT_ID_READ: begin
					if (rdata_valid) begin
						ram_ok <= (rdata[3:0] == hyperram_pkg::ID_VENDOR);
						if (rdata[3:0] == hyperram_pkg::ID_VENDOR) begin
							num_col_addrs  <= {1'b0, rdata[7:4]} + 5'd1;
							num_row_addrs  <= {1'b0, rdata[12:8]} + 6'd1;
							capacity_mbits <= 8'd1 << cap_shift;
						end
					end
					if (done) begin
						req       <= 1'b1;			// Then program CR0
						req_burst <= '{rd: 1'b0, is_reg: 1'b1, is_linear: 1'b1,
							upper_addr: hyperram_pkg::CR0_UPPER_ADDR, lower_addr: '0,
							len: 8'd1};
						state     <= hyperram_pkg::BOOT_CR0_WRITE;
					end
				end
				hyperram_pkg::BOOT_CR0_WRITE: begin
					if (done) begin
						status_valid <= 1'b1;		// Host port may start now
						state        <= hyperram_pkg::BOOT_DONE;
					end
				end
				default: state <= hyperram_pkg::BOOT_DONE;
			endcase
		end
	end

	// Only one word is ever written, the CR0 setting
	always_ff @(posedge clk) begin
		if (need_wdata)
			wdata <= hyperram_pkg::CR0_VALUE;
	end

	// Once booted the channel belongs to the host
	assert property (@(posedge clk) disable iff (rst)
		state == hyperram_pkg::BOOT_DONE |-> !req)
		else $error("boot request after boot finished");

endmodule

//--- logic/hyperram_host_port.sv
`timescale 1ns/1ns
module hyperram_host_port #(
	parameter int HOST_BURST_LEN = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     status_valid,
	input  logic                     bus_en,
	input  logic                     bus_rd,
	input  logic [31:0]              bus_addr,
	input  logic [31:0]              bus_wdata,
	input  logic                     need_wdata,
	input  logic                     rdata_valid,
	input  logic [15:0]              rdata,
	input  logic                     done,
	output logic                     bus_need_wdata,
	output logic                     bus_rdata_valid,
	output logic [31:0]              bus_rdata,
	output logic                     bus_done,
	output logic                     req,
	output hyperram_pkg::burst_req_t req_burst,
	output logic [15:0]              wdata
);

	localparam logic [hyperram_pkg::LEN_W-1:0] BURST_LEN =
		HOST_BURST_LEN[hyperram_pkg::LEN_W-1:0];

	logic        busy;
	logic        phase;			// 0 = upper half next
	logic        sel_hi;		// Half the PHY takes on its next use
	logic [15:0] lo_hold;
	logic [15:0] hi_hold;

	// Ask the host only for upper halves, lower halves come from lo_hold
	assign bus_need_wdata = need_wdata && !phase;
	assign wdata          = sel_hi ? bus_wdata[31:16] : lo_hold;

	always_ff @(posedge clk) begin
		req             <= 1'b0;
		bus_done        <= 1'b0;
		bus_rdata_valid <= 1'b0;
		if (rst) begin
			busy   <= 1'b0;
			phase  <= 1'b0;
			sel_hi <= 1'b0;
		end else begin
			// Strobes while busy or before boot are dropped
			if (!busy && status_valid && bus_en) begin
				req       <= 1'b1;
				busy      <= 1'b1;
				phase     <= 1'b0;
				req_burst <= '{rd: bus_rd, is_reg: 1'b0, is_linear: 1'b1,
					upper_addr: bus_addr[31:3], lower_addr: bus_addr[2:0], len: BURST_LEN};
			end
			if (need_wdata)
				sel_hi <= !phase;
			if (need_wdata || rdata_valid)
				phase <= !phase;
			if (rdata_valid && phase)
				bus_rdata_valid <= 1'b1;	// Second half completes the word
			if (done) begin
				busy     <= 1'b0;
				bus_done <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data halves

	always_ff @(posedge clk) begin
		if (sel_hi)
			lo_hold <= bus_wdata[15:0];		// Host word is stable this cycle
		if (rdata_valid && !phase)
			hi_hold <= rdata;
		if (rdata_valid && phase)
			bus_rdata <= {hi_hold, rdata};	// First RAM word on top
	end

	// A burst is either all read or all write
	assert property (@(posedge clk) disable iff (rst)
		!(bus_rdata_valid && bus_need_wdata))
		else $error("read and write strobes together");

endmodule

//--- logic/hyperram_arbiter.sv
`timescale 1ns/1ns
module hyperram_arbiter (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     boot_req,
	input  hyperram_pkg::burst_req_t boot_burst,
	input  logic [15:0]              boot_wdata,
	input  logic                     host_req,
	input  hyperram_pkg::burst_req_t host_burst,
	input  logic [15:0]              host_wdata,
	input  logic                     phy_need_wdata,
	input  logic                     phy_rdata_valid,
	input  logic [15:0]              phy_rdata,
	input  logic                     phy_done,
	output logic                     phy_req,
	output hyperram_pkg::burst_req_t phy_burst,
	output logic [15:0]              phy_wdata,
	output logic                     boot_need_wdata,
	output logic                     boot_rdata_valid,
	output logic [15:0]              boot_rdata,
	output logic                     boot_done,
	output logic                     host_need_wdata,
	output logic                     host_rdata_valid,
	output logic [15:0]              host_rdata,
	output logic                     host_done
);

	logic owner_host;		// 1 = host owns the PHY
	logic busy;

	// Requests come straight through, the owner is picked on the strobe
	assign phy_req   = boot_req || host_req;
	assign phy_burst = host_req ? host_burst : boot_burst;
	assign phy_wdata = owner_host ? host_wdata : boot_wdata;

	// Strobes back to the owner only
	assign boot_need_wdata  = phy_need_wdata && !owner_host;
	assign boot_rdata_valid = phy_rdata_valid && !owner_host;
	assign boot_done        = phy_done && !owner_host;
	assign host_need_wdata  = phy_need_wdata && owner_host;
	assign host_rdata_valid = phy_rdata_valid && owner_host;
	assign host_done        = phy_done && owner_host;
	assign boot_rdata       = phy_rdata;
	assign host_rdata       = phy_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			owner_host <= 1'b0;
			busy       <= 1'b0;
		end else if (phy_req) begin
			owner_host <= host_req;
			busy       <= 1'b1;
		end else if (phy_done)
			busy <= 1'b0;		// Grant held to the end of the burst
	end

	// Boot finishes before the host may start, so requests never overlap
	assert property (@(posedge clk) disable iff (rst)
		(boot_req || host_req) |-> (!busy && !(boot_req && host_req)))
		else $error("PHY request while busy or from both sides");

endmodule

//--- logic/hyperram_controller.sv
`timescale 1ns/1ns
module hyperram_controller #(
	parameter int RST_LOW_CYCLES  = 64,
	parameter int RST_WAIT_CYCLES = 128,
	parameter int WRITE_LATENCY   = 9,
	parameter int HOST_BURST_LEN  = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       bus_en,
	input  logic                       bus_rd,
	input  logic [31:0]                bus_addr,
	input  logic [31:0]                bus_wdata,
	input  hyperram_pkg::hr_pins_in_t  ram_in,
	output hyperram_pkg::hr_pins_out_t ram_out,
	output logic                       bus_need_wdata,
	output logic                       bus_rdata_valid,
	output logic [31:0]                bus_rdata,
	output logic                       bus_done,
	output logic                       status_valid,
	output logic                       ram_ok,
	output logic [4:0]                 num_col_addrs,
	output logic [5:0]                 num_row_addrs,
	output logic [7:0]                 capacity_mbits
);

	//////////////////////////////////////////////////////////////////////
	// Channel wiring

	logic ram_rst_n;
	logic boot_req, boot_need_wdata, boot_rdata_valid, boot_done;
	logic host_req, host_need_wdata, host_rdata_valid, host_done;
	logic phy_req, phy_need_wdata, phy_rdata_valid, phy_done;
	logic [15:0] boot_wdata, boot_rdata, host_wdata, host_rdata, phy_wdata, phy_rdata;
	hyperram_pkg::burst_req_t boot_burst, host_burst, phy_burst;

	hyperram_boot #(
		.RST_LOW_CYCLES (RST_LOW_CYCLES),
		.RST_WAIT_CYCLES(RST_WAIT_CYCLES)
	) boot (
		.clk(clk), .rst(rst),
		.need_wdata(boot_need_wdata), .rdata_valid(boot_rdata_valid),
		.rdata(boot_rdata), .done(boot_done),
		.ram_rst_n(ram_rst_n), .req(boot_req), .req_burst(boot_burst), .wdata(boot_wdata),
		.status_valid(status_valid), .ram_ok(ram_ok), .num_col_addrs(num_col_addrs),
		.num_row_addrs(num_row_addrs), .capacity_mbits(capacity_mbits)
	);

	hyperram_host_port #(
		.HOST_BURST_LEN(HOST_BURST_LEN)
	) host (
		.clk(clk), .rst(rst), .status_valid(status_valid),
		.bus_en(bus_en), .bus_rd(bus_rd), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.need_wdata(host_need_wdata), .rdata_valid(host_rdata_valid),
		.rdata(host_rdata), .done(host_done),
		.bus_need_wdata(bus_need_wdata), .bus_rdata_valid(bus_rdata_valid),
		.bus_rdata(bus_rdata), .bus_done(bus_done),
		.req(host_req), .req_burst(host_burst), .wdata(host_wdata)
	);

	hyperram_arbiter arb (
		.clk(clk), .rst(rst),
		.boot_req(boot_req), .boot_burst(boot_burst), .boot_wdata(boot_wdata),
		.host_req(host_req), .host_burst(host_burst), .host_wdata(host_wdata),
		.phy_need_wdata(phy_need_wdata), .phy_rdata_valid(phy_rdata_valid),
		.phy_rdata(phy_rdata), .phy_done(phy_done),
		.phy_req(phy_req), .phy_burst(phy_burst), .phy_wdata(phy_wdata),
		.boot_need_wdata(boot_need_wdata), .boot_rdata_valid(boot_rdata_valid),
		.boot_rdata(boot_rdata), .boot_done(boot_done),
		.host_need_wdata(host_need_wdata), .host_rdata_valid(host_rdata_valid),
		.host_rdata(host_rdata), .host_done(host_done)
	);

	hyperram_phy #(
		.WRITE_LATENCY(WRITE_LATENCY)
	) phy (
		.clk(clk), .rst(rst), .ram_rst_n(ram_rst_n),
		.req(phy_req), .burst(phy_burst), .wdata(phy_wdata), .ram_in(ram_in),
		.ram_out(ram_out), .need_wdata(phy_need_wdata), .rdata_valid(phy_rdata_valid),
		.rdata(phy_rdata), .done(phy_done)
	);

endmodule

//--- tb/hyperram_model.sv
`timescale 1ns/1ns
module hyperram_model #(
	parameter int WRITE_LATENCY = 9
) (
	input  logic                       clk,
	input  hyperram_pkg::hr_pins_out_t pins_out,
	output hyperram_pkg::hr_pins_in_t  pins_in,
	input  logic                       slip,		// Reads come half a word late
	input  logic [3:0]                 read_delay,	// Extra strobe-low cycles
	input  logic [15:0]                id_value,	// Returned by ID register 0
	output logic [15:0]                cr0,
	output logic                       cmd_rd,
	output logic                       cmd_reg,
	output logic                       cmd_linear,
	output logic [31:0]                cmd_addr,	// Word address from the CA words
	output int                         cmd_count
);

	localparam int DATA_IDX = 3 + WRITE_LATENCY + 1;	// First write word after CS low

	logic [15:0] mem [0:1023];
	logic [15:0] ca_hi;
	logic [15:0] ca_mid;
	logic [15:0] cur_word;
	logic [15:0] last_word;		// Previous word, feeds the slipped beat
	logic        rd_slip;
	int          idx;			// Cycles since CS fell
	int          wait_left;
	int          beat;

	function automatic logic [15:0] read_word(input int k);
		if (cmd_reg)
			return (cmd_addr == 32'd0) ? id_value : 16'h0000;
		return mem[(cmd_addr + k) & 32'h3ff];
	endfunction

	initial begin
		int i;
		pins_in   = '{dq: 16'h0000, dqs: 2'b11};
		cr0       = 16'h0000;
		cmd_count = 0;
		idx       = 0;
		for (i = 0; i < 1024; i++)
			mem[i] = {~i[5:0], i[9:0]};		// Address-dependent fill
	end

	//////////////////////////////////////////////////////////////////////
	// Bus side, sampled mid-cycle

	always @(negedge clk) begin
		if (!pins_out.rst_n)
			cr0 = 16'h0000;					// Registers back to defaults
		if (pins_out.cs_n) begin
			idx     = 0;
			pins_in = '{dq: 16'h0000, dqs: 2'b11};	// Idle strobe, no data
		end else begin
			if (idx == 0)
				ca_hi = pins_out.dq;
			else if (idx == 1)
				ca_mid = pins_out.dq;
			else if (idx == 2) begin
				cmd_rd     = ca_hi[15];
				cmd_reg    = ca_hi[14];
				cmd_linear = ca_hi[13];
				cmd_addr   = {ca_hi[12:0], ca_mid, pins_out.dq[2:0]};
				cmd_count  = cmd_count + 1;
				rd_slip    = slip;
				wait_left  = 1 + read_delay;	// At least one cycle of strobe low
				beat       = 0;
				last_word  = 16'h0000;
			end
			// Write data, fixed latency for memory only
			if (idx >= 3 && !cmd_rd) begin
				if (cmd_reg && idx == 3 && cmd_addr == {hyperram_pkg::CR0_UPPER_ADDR, 3'b000})
					cr0 = pins_out.dq;
				else if (!cmd_reg && idx >= DATA_IDX)
					mem[(cmd_addr + idx - DATA_IDX) & 32'h3ff] = pins_out.dq;
			end
			// Read data streams until CS rises
			if (idx >= 2 && cmd_rd) begin
				if (wait_left > 0) begin
					pins_in   = '{dq: 16'h0000, dqs: 2'b00};
					wait_left = wait_left - 1;
				end else begin
					cur_word = read_word(beat);
					if (rd_slip)
						pins_in = '{dq: {last_word[7:0], cur_word[15:8]}, dqs: 2'b01};
					else
						pins_in = '{dq: cur_word, dqs: 2'b10};
					last_word = cur_word;
					beat      = beat + 1;
				end
			end
			idx = idx + 1;
		end
	end

endmodule

//--- tb/tb_hyperram_controller.sv
`timescale 1ns/1ns
module tb_hyperram_controller;

	localparam int RST_LOW_CYCLES  = 64;
	localparam int RST_WAIT_CYCLES = 128;
	localparam int WRITE_LATENCY   = 9;
	localparam int HOST_BURST_LEN  = 16;
	localparam int HOST_WORDS      = HOST_BURST_LEN / 2;
	localparam int NUM_BURSTS      = 40;
	localparam int BURST_COUNT     = NUM_BURSTS + 4;	// Random mix plus directed bursts
	localparam int CLK_PERIOD      = 20;
	localparam logic [15:0] ID_GOOD = 16'h0c81;		// 13 row bits, 9 column bits, vendor 1
	localparam logic [15:0] ID_BAD  = 16'h0c82;		// Wrong vendor

	logic        clk;
	logic        rst;
	logic        bus_en;
	logic        bus_rd;
	logic [31:0] bus_addr;
	logic [31:0] bus_wdata;
	logic        bus_need_wdata;
	logic        bus_rdata_valid;
	logic [31:0] bus_rdata;
	logic        bus_done;
	logic        status_valid;
	logic        ram_ok;
	logic [4:0]  num_col_addrs;
	logic [5:0]  num_row_addrs;
	logic [7:0]  capacity_mbits;
	hyperram_pkg::hr_pins_in_t  ram_in;
	hyperram_pkg::hr_pins_out_t ram_out;

	logic        slip;
	logic [3:0]  read_delay;
	logic [15:0] id_value;
	logic [15:0] cr0;
	logic        cmd_rd;
	logic        cmd_reg;
	logic        cmd_linear;
	logic [31:0] cmd_addr;
	int          cmd_count;

	integer      seed;
	logic [31:0] ref_mem [0:511];	// Host words indexed by RAM word address / 2
	logic [31:0] written [$];		// Burst addresses with known contents

	hyperram_controller #(
		.RST_LOW_CYCLES (RST_LOW_CYCLES),
		.RST_WAIT_CYCLES(RST_WAIT_CYCLES),
		.WRITE_LATENCY  (WRITE_LATENCY),
		.HOST_BURST_LEN (HOST_BURST_LEN)
	) UUT (
		.clk(clk), .rst(rst), .bus_en(bus_en), .bus_rd(bus_rd), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .ram_in(ram_in), .ram_out(ram_out),
		.bus_need_wdata(bus_need_wdata), .bus_rdata_valid(bus_rdata_valid),
		.bus_rdata(bus_rdata), .bus_done(bus_done), .status_valid(status_valid),
		.ram_ok(ram_ok), .num_col_addrs(num_col_addrs), .num_row_addrs(num_row_addrs),
		.capacity_mbits(capacity_mbits)
	);

	hyperram_model #(
		.WRITE_LATENCY(WRITE_LATENCY)
	) model (
		.clk(clk), .pins_out(ram_out), .pins_in(ram_in), .slip(slip),
		.read_delay(read_delay), .id_value(id_value), .cr0(cr0), .cmd_rd(cmd_rd),
		.cmd_reg(cmd_reg), .cmd_linear(cmd_linear), .cmd_addr(cmd_addr),
		.cmd_count(cmd_count)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Hang guard sized from the burst count and two boots
	initial begin
		#((BURST_COUNT * 200 + 1000) * CLK_PERIOD);
		$display("Timeout: the run took longer than the tests allow");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("*** FAILED ***");
		$fatal(1, "wait limit reached");
	endtask

	// Reset, then follow the boot sequence to status_valid
	task automatic reset_and_boot(input logic [15:0] id);
		int low_cycles;
		int n;
		id_value = id;
		rst      = 1'b1;
		repeat (5) @(negedge clk);
		check_value("cs_n", ram_out.cs_n, 1'b1);
		check_value("rst_n", ram_out.rst_n, 1'b1);
		check_value("ck_en", ram_out.ck_en, 1'b0);
		check_value("dq_oe", ram_out.dq_oe, 1'b0);
		check_value("dqs_oe", ram_out.dqs_oe, 1'b0);
		check_value("status_valid", status_valid, 1'b0);
		check_value("ram_ok", ram_ok, 1'b0);
		check_value("bus_done", bus_done, 1'b0);
		check_value("bus_rdata_valid", bus_rdata_valid, 1'b0);
		check_value("bus_need_wdata", bus_need_wdata, 1'b0);
		rst = 1'b0;
		@(negedge clk);
		low_cycles = 0;
		while (!ram_out.rst_n && low_cycles < 1000) begin
			low_cycles++;
			@(negedge clk);
		end
		check_value("rst_n low cycles", low_cycles, RST_LOW_CYCLES);
		n = 0;
		while (!status_valid) begin
			if (n == 1000)
				stop_on_timeout("status_valid never rose after boot");
			n++;
			@(negedge clk);
		end
		check_value("cr0", cr0, hyperram_pkg::CR0_VALUE);
	endtask

	// One host burst with an optional second strobe while it runs
	task automatic run_burst(input logic rd, input logic [31:0] addr, input logic inject,
		input logic [31:0] inject_addr);
		int   n;
		int   k_w;
		int   k_r;
		int   cnt0;
		logic pend;
		logic done_seen;
		cnt0      = cmd_count;
		bus_en    = 1'b1;
		bus_rd    = rd;
		bus_addr  = addr;
		n         = 0;
		k_w       = 0;
		k_r       = 0;
		pend      = 1'b0;
		done_seen = 1'b0;
		while (!done_seen) begin
			@(negedge clk);
			bus_en = inject && (n == 8);
			if (inject && n == 8) begin
				bus_rd   = 1'b0;			// Stray write request
				bus_addr = inject_addr;
			end
			if (!ram_out.cs_n)
				check_value("dm", ram_out.dm, 2'b00);	// Whole words, no byte mask
			if (pend) begin
				bus_wdata = $random(seed);	// Word asked for last cycle
				ref_mem[(addr >> 1) + k_w] = bus_wdata;
				k_w++;
			end
			pend = bus_need_wdata;
			if (bus_rdata_valid) begin
				check_value("bus_rdata", bus_rdata, ref_mem[(addr >> 1) + k_r]);
				k_r++;
			end
			done_seen = bus_done;
			if (n == 200)
				stop_on_timeout("host burst never signalled bus_done");
			n++;
		end
		check_value("bus_rdata_valid count", k_r, rd ? HOST_WORDS : 0);
		check_value("bus_need_wdata count", k_w, rd ? 0 : HOST_WORDS);
		check_value("cmd_count", cmd_count, cnt0 + 1);
		check_value("cmd_rd", cmd_rd, rd);
		check_value("cmd_reg", cmd_reg, 1'b0);
		check_value("cmd_linear", cmd_linear, 1'b1);
		check_value("cmd_addr", cmd_addr, addr);
		if (!rd)
			written.push_back(addr);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int          i;
		int          cnt0;
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] other;
		seed       = 32'h2b35c908;
		rst        = 1'b1;
		bus_en     = 1'b0;
		bus_rd     = 1'b0;
		bus_addr   = 32'h0;
		bus_wdata  = 32'h0;
		slip       = 1'b0;
		read_delay = 4'd2;
		id_value   = ID_GOOD;

		reset_and_boot(ID_GOOD);
		check_value("ram_ok", ram_ok, 1'b1);
		check_value("num_col_addrs", num_col_addrs, ID_GOOD[7:4] + 1);
		check_value("num_row_addrs", num_row_addrs, ID_GOOD[12:8] + 1);
		check_value("capacity_mbits", capacity_mbits,
			1 << (ID_GOOD[7:4] + ID_GOOD[12:8] - 14));

		// Random writes and read-backs of earlier writes
		for (i = 0; i < NUM_BURSTS; i++) begin
			rnd        = $random(seed);
			slip       = rnd[0];
			read_delay = {1'b0, rnd[3:1]};
			if (written.size() == 0 || rnd[8]) begin
				addr = ($unsigned($random(seed)) % 127) << 3;	// Whole burst fits memory
				run_burst(1'b0, addr, 1'b0, 32'h0);
			end else begin
				addr = written[$unsigned($random(seed)) % written.size()];
				run_burst(1'b1, addr, 1'b0, 32'h0);
			end
		end

		// Same data with and without the half-word slip
		slip = 1'b0;
		run_burst(1'b1, written[0], 1'b0, 32'h0);
		slip = 1'b1;
		run_burst(1'b1, written[0], 1'b0, 32'h0);

		// Stray strobe mid burst is dropped
		slip  = 1'b0;
		other = written[written.size() - 1];
		run_burst(1'b1, written[0], 1'b1, other);
		cnt0 = cmd_count;
		repeat (60) begin
			@(negedge clk);
			check_value("bus_done", bus_done, 1'b0);
		end
		check_value("cmd_count", cmd_count, cnt0);
		run_burst(1'b1, other, 1'b0, 32'h0);

		// Second boot with a foreign vendor in the ID
		reset_and_boot(ID_BAD);
		check_value("ram_ok", ram_ok, 1'b0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- hyperram_controller.f
logic/hyperram_pkg.sv
logic/hyperram_phy.sv
logic/hyperram_boot.sv
logic/hyperram_host_port.sv
logic/hyperram_arbiter.sv
logic/hyperram_controller.sv
tb/hyperram_model.sv
tb/tb_hyperram_controller.sv

//--- Bender.yml
package:
  name: hyperram_controller

sources:
  - files:
      - logic/hyperram_pkg.sv
      - logic/hyperram_phy.sv
      - logic/hyperram_boot.sv
      - logic/hyperram_host_port.sv
      - logic/hyperram_arbiter.sv
      - logic/hyperram_controller.sv
  - target: test
    files:
      - tb/hyperram_model.sv
      - tb/tb_hyperram_controller.sv
